// File: rtl/read_pipe_pkg.sv
//==============================
// Shared widths, slot geometry and types of the read pipeline.
// RTL and testbench refer to these by package-scoped names.
//==============================

package read_pipe_pkg;

	//==============================
	// Geometry
	//==============================
	localparam int VSIZE      = 4;
	localparam int DBW        = 16;
	localparam int N_SLOT     = 2;
	localparam int SLOT_ROWS  = 8;
	localparam int LBW        = 4;
	localparam int GBW        = 8;

	// Derived widths
	localparam int ROW_BW     = $clog2(SLOT_ROWS);
	localparam int CNT_BW     = $clog2(SLOT_ROWS + 1);
	localparam int SLOT_BW    = $clog2(N_SLOT);
	localparam int XOR_BW     = $clog2(VSIZE);
	localparam int BANK_DEPTH = 2 ** LBW;

	//==============================
	// Types
	//==============================
	typedef logic [DBW-1:0]     lane_t;
	typedef logic [ROW_BW-1:0]  row_t;
	// Row or read count, 1 to SLOT_ROWS
	typedef logic [CNT_BW-1:0]  rows_t;
	typedef logic [SLOT_BW-1:0] slot_t;
	// Local address is {slot, row}
	typedef logic [LBW-1:0]     laddr_t;
	typedef logic [GBW-1:0]     gaddr_t;
	typedef logic [XOR_BW-1:0]  xor_t;

	typedef enum logic [1:0] {
		ALLOC_IDLE,
		ALLOC_NOTIFY,
		ALLOC_FILL
	} alloc_state_e;

	typedef enum logic {
		LOOP_IDLE,
		LOOP_RUN
	} loop_state_e;

endpackage

// File: rtl/buffer_allocator.sv
//==============================
// Buffer slot allocator. Takes a request, reserves a free slot,
// notifies the DMA, counts its write strobes and then releases
// the job to the address looper. Slots come back by free pulse.
//==============================

module buffer_allocator (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// Request
	input  logic                  i_bofs_rdy,
	output logic                  o_bofs_ack,
	input  read_pipe_pkg::gaddr_t i_bofs,
	input  read_pipe_pkg::rows_t  i_rows,
	input  read_pipe_pkg::row_t   i_first,
	input  read_pipe_pkg::row_t   i_step,
	input  read_pipe_pkg::rows_t  i_count,
	// DMA notify
	output logic                  o_rp_en_rdy,
	input  logic                  i_rp_en_ack,
	output read_pipe_pkg::slot_t  o_rp_en_slot,
	output read_pipe_pkg::gaddr_t o_rp_en_bofs,
	output read_pipe_pkg::rows_t  o_rp_en_rows,
	// DMA write strobe
	input  logic                  i_dma_write_dval,
	// Job to looper
	output logic                  o_job_rdy,
	input  logic                  i_job_ack,
	output read_pipe_pkg::slot_t  o_job_slot,
	output read_pipe_pkg::rows_t  o_job_rows,
	output read_pipe_pkg::row_t   o_job_first,
	output read_pipe_pkg::row_t   o_job_step,
	output read_pipe_pkg::rows_t  o_job_count,
	// Slot release
	input  logic                  i_free_dval,
	input  read_pipe_pkg::slot_t  i_free_slot
);

logic [read_pipe_pkg::N_SLOT-1:0] busy;
logic [read_pipe_pkg::N_SLOT-1:0] avail;
logic                             has_free;
read_pipe_pkg::slot_t             pick_slot;

read_pipe_pkg::alloc_state_e state;
logic                        ack_r;
logic                        job_rdy_r;
read_pipe_pkg::rows_t        wcnt;

// Latched request
read_pipe_pkg::slot_t  slot_r;
read_pipe_pkg::gaddr_t bofs_r;
read_pipe_pkg::rows_t  rows_r;
read_pipe_pkg::row_t   first_r;
read_pipe_pkg::row_t   step_r;
read_pipe_pkg::rows_t  count_r;

logic req_xfer;
logic rp_xfer;
logic job_xfer;

assign req_xfer = i_bofs_rdy & ack_r;
assign rp_xfer  = o_rp_en_rdy & i_rp_en_ack;
assign job_xfer = job_rdy_r & i_job_ack;

//==============================
// Slot selection
//==============================
// A free pulse makes its slot available in the same cycle
always_comb begin
	avail = ~busy;
	if (i_free_dval) begin
		avail[i_free_slot] = 1'b1;
	end
	has_free = |avail;
	// Downward scan so the lowest free slot wins
	pick_slot = '0;
	for (int s = read_pipe_pkg::N_SLOT - 1; s >= 0; s--) begin
		if (avail[s]) begin
			pick_slot = read_pipe_pkg::slot_t'(s);
		end
	end
end

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		busy <= '0;
	end else begin
		if (i_free_dval) begin
			busy[i_free_slot] <= 1'b0;
		end
		if (req_xfer) begin
			busy[pick_slot] <= 1'b1;
		end
	end
end

//==============================
// Request, notify, fill
//==============================
always_ff @(posedge i_clk) begin
	if (i_reset) begin
		state     <= read_pipe_pkg::ALLOC_IDLE;
		ack_r     <= 1'b0;
		job_rdy_r <= 1'b0;
		wcnt      <= '0;
	end else begin
		case (state)
			read_pipe_pkg::ALLOC_IDLE: begin
				if (req_xfer) begin
					ack_r <= 1'b0;
					state <= read_pipe_pkg::ALLOC_NOTIFY;
				end else begin
					ack_r <= i_bofs_rdy & has_free;
				end
			end
			read_pipe_pkg::ALLOC_NOTIFY: begin
				if (rp_xfer) begin
					wcnt  <= '0;
					state <= read_pipe_pkg::ALLOC_FILL;
				end
			end
			read_pipe_pkg::ALLOC_FILL: begin
				if (job_xfer) begin
					job_rdy_r <= 1'b0;
					state     <= read_pipe_pkg::ALLOC_IDLE;
				end else if (i_dma_write_dval && !job_rdy_r) begin
					wcnt <= wcnt + read_pipe_pkg::rows_t'(1);
					// Last row of the block has landed
					if (wcnt + read_pipe_pkg::rows_t'(1) == rows_r) begin
						job_rdy_r <= 1'b1;
					end
				end
			end
			default: begin
				state <= read_pipe_pkg::ALLOC_IDLE;
			end
		endcase
	end
end

always_ff @(posedge i_clk) begin
	if (req_xfer) begin
		slot_r  <= pick_slot;
		bofs_r  <= i_bofs;
		rows_r  <= i_rows;
		first_r <= i_first;
		step_r  <= i_step;
		count_r <= i_count;
	end
end

assign o_bofs_ack   = ack_r;
assign o_rp_en_rdy  = (state == read_pipe_pkg::ALLOC_NOTIFY);
assign o_rp_en_slot = slot_r;
assign o_rp_en_bofs = bofs_r;
assign o_rp_en_rows = rows_r;
assign o_job_rdy    = job_rdy_r;
assign o_job_slot   = slot_r;
assign o_job_rows   = rows_r;
assign o_job_first  = first_r;
assign o_job_step   = step_r;
assign o_job_count  = count_r;

endmodule

// File: rtl/warp_address_looper.sv
//==============================
// Address looper. Accepts one job at a time and emits count local
// addresses walking first, first+step, ... modulo the block rows.
// Retire marks the last address of the job.
//==============================

module warp_address_looper (
	input  logic                   i_clk,
	input  logic                   i_reset,
	// Job from allocator
	input  logic                   i_job_rdy,
	output logic                   o_job_ack,
	input  read_pipe_pkg::slot_t   i_job_slot,
	input  read_pipe_pkg::rows_t   i_job_rows,
	input  read_pipe_pkg::row_t    i_job_first,
	input  read_pipe_pkg::row_t    i_job_step,
	input  read_pipe_pkg::rows_t   i_job_count,
	// Address to remap buffer
	output logic                   o_addr_rdy,
	input  logic                   i_addr_ack,
	output read_pipe_pkg::laddr_t  o_addr,
	output logic                   o_retire
);

read_pipe_pkg::loop_state_e state;

read_pipe_pkg::slot_t slot_r;
read_pipe_pkg::rows_t rows_r;
read_pipe_pkg::row_t  step_r;
read_pipe_pkg::row_t  row_r;
// Reads still to send including the current one
read_pipe_pkg::rows_t left_r;

read_pipe_pkg::rows_t row_sum;
read_pipe_pkg::row_t  row_next;

logic job_xfer;
logic addr_xfer;

assign job_xfer  = i_job_rdy & o_job_ack;
assign addr_xfer = o_addr_rdy & i_addr_ack;

//==============================
// Row stepping
//==============================
// Wider sum so the wrap test sees the carry
assign row_sum = read_pipe_pkg::rows_t'(row_r) + read_pipe_pkg::rows_t'(step_r);

always_comb begin
	if (row_sum >= rows_r) begin
		row_next = read_pipe_pkg::row_t'(row_sum - rows_r);
	end else begin
		row_next = read_pipe_pkg::row_t'(row_sum);
	end
end

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		state <= read_pipe_pkg::LOOP_IDLE;
	end else begin
		case (state)
			read_pipe_pkg::LOOP_IDLE: begin
				if (job_xfer) begin
					state <= read_pipe_pkg::LOOP_RUN;
				end
			end
			read_pipe_pkg::LOOP_RUN: begin
				if (addr_xfer && o_retire) begin
					state <= read_pipe_pkg::LOOP_IDLE;
				end
			end
			default: begin
				state <= read_pipe_pkg::LOOP_IDLE;
			end
		endcase
	end
end

always_ff @(posedge i_clk) begin
	if (job_xfer) begin
		slot_r <= i_job_slot;
		rows_r <= i_job_rows;
		step_r <= i_job_step;
		row_r  <= i_job_first;
		left_r <= i_job_count;
	end else if (addr_xfer) begin
		row_r  <= row_next;
		left_r <= left_r - read_pipe_pkg::rows_t'(1);
	end
end

assign o_job_ack  = (state == read_pipe_pkg::LOOP_IDLE);
assign o_addr_rdy = (state == read_pipe_pkg::LOOP_RUN);
assign o_addr     = {slot_r, row_r};
assign o_retire   = (left_r == read_pipe_pkg::rows_t'(1));

endmodule

// File: rtl/remap_buffer.sv
//==============================
// Banked local buffer. Each row is stored as VSIZE lanes spread
// over VSIZE banks with an XOR lane swizzle, and read back in
// lane order through a one-deep output register. A retiring read
// frees its slot once the output transfer is done.
//==============================

module remap_buffer (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  read_pipe_pkg::xor_t    i_xor_mask,
	// DMA write port
	input  logic                   i_dma_write_dval,
	input  read_pipe_pkg::laddr_t  i_dma_whiaddr,
	input  read_pipe_pkg::lane_t   i_dma_wdata [read_pipe_pkg::VSIZE],
	// Address from looper
	input  logic                   i_addr_rdy,
	output logic                   o_addr_ack,
	input  read_pipe_pkg::laddr_t  i_addr,
	input  logic                   i_retire,
	// Read data out
	output logic                   o_sramrd_rdy,
	input  logic                   i_sramrd_ack,
	output read_pipe_pkg::lane_t   o_sramrd [read_pipe_pkg::VSIZE],
	// Slot release to allocator
	output logic                   o_free_dval,
	output read_pipe_pkg::slot_t   o_free_slot
);

read_pipe_pkg::lane_t bank [read_pipe_pkg::VSIZE][read_pipe_pkg::BANK_DEPTH];
read_pipe_pkg::lane_t bank_rd [read_pipe_pkg::VSIZE];

read_pipe_pkg::xor_t wr_swz;
read_pipe_pkg::xor_t rd_swz;

logic                 accept;
logic                 out_xfer;
logic                 rd_rdy_r;
logic                 retire_r;
logic                 free_dval_r;
read_pipe_pkg::slot_t out_slot_r;
read_pipe_pkg::slot_t free_slot_r;

// Swizzle term from the low row bits
assign wr_swz = i_dma_whiaddr[read_pipe_pkg::XOR_BW-1:0] & i_xor_mask;
assign rd_swz = i_addr[read_pipe_pkg::XOR_BW-1:0] & i_xor_mask;

//==============================
// Storage
//==============================
// Bank b takes lane b^swz, the same map as lane l to bank l^swz
always_ff @(posedge i_clk) begin
	if (i_dma_write_dval) begin
		for (int b = 0; b < read_pipe_pkg::VSIZE; b++) begin
			bank[b][i_dma_whiaddr] <= i_dma_wdata[read_pipe_pkg::xor_t'(b) ^ wr_swz];
		end
	end
end

always_comb begin
	for (int b = 0; b < read_pipe_pkg::VSIZE; b++) begin
		bank_rd[b] = bank[b][i_addr];
	end
end

//==============================
// Output register
//==============================
// Take a new address when the register is empty or draining now
assign out_xfer   = rd_rdy_r & i_sramrd_ack;
assign o_addr_ack = ~rd_rdy_r | i_sramrd_ack;
assign accept     = i_addr_rdy & o_addr_ack;

always_ff @(posedge i_clk) begin
	if (i_reset) begin
		rd_rdy_r    <= 1'b0;
		free_dval_r <= 1'b0;
	end else begin
		if (accept) begin
			rd_rdy_r <= 1'b1;
		end else if (i_sramrd_ack) begin
			rd_rdy_r <= 1'b0;
		end
		free_dval_r <= out_xfer & retire_r;
	end
end

always_ff @(posedge i_clk) begin
	if (accept) begin
		// Undo the swizzle, lane l sits in bank l^swz
		for (int l = 0; l < read_pipe_pkg::VSIZE; l++) begin
			o_sramrd[l] <= bank_rd[read_pipe_pkg::xor_t'(l) ^ rd_swz];
		end
		retire_r   <= i_retire;
		out_slot_r <= read_pipe_pkg::slot_t'(
			i_addr[read_pipe_pkg::LBW-1 -: read_pipe_pkg::SLOT_BW]);
	end
	if (out_xfer) begin
		free_slot_r <= out_slot_r;
	end
end

assign o_sramrd_rdy = rd_rdy_r;
assign o_free_dval  = free_dval_r;
assign o_free_slot  = free_slot_r;

endmodule

// File: rtl/read_pipeline.sv
//==============================
// Read pipeline top. Request goes to the allocator, the DMA fills
// a slot, the looper walks the rows and the remap buffer returns
// vectors on the sramrd port.
//==============================

module read_pipeline (
	input  logic                   i_clk,
	input  logic                   i_reset,
	// Request
	input  logic                   i_bofs_rdy,
	output logic                   o_bofs_ack,
	input  read_pipe_pkg::gaddr_t  i_bofs,
	input  read_pipe_pkg::rows_t   i_rows,
	input  read_pipe_pkg::row_t    i_first,
	input  read_pipe_pkg::row_t    i_step,
	input  read_pipe_pkg::rows_t   i_count,
	// DMA notify
	output logic                   o_rp_en_rdy,
	input  logic                   i_rp_en_ack,
	output read_pipe_pkg::slot_t   o_rp_en_slot,
	output read_pipe_pkg::gaddr_t  o_rp_en_bofs,
	output read_pipe_pkg::rows_t   o_rp_en_rows,
	// DMA write
	input  logic                   i_dma_write_dval,
	input  read_pipe_pkg::laddr_t  i_dma_whiaddr,
	input  read_pipe_pkg::lane_t   i_dma_wdata [read_pipe_pkg::VSIZE],
	// Held while any slot is busy
	input  read_pipe_pkg::xor_t    i_xor_mask,
	// Read output
	output logic                   o_sramrd_rdy,
	input  logic                   i_sramrd_ack,
	output read_pipe_pkg::lane_t   o_sramrd [read_pipe_pkg::VSIZE]
);

//==============================
// Internal links
//==============================
logic                  job_rdy;
logic                  job_ack;
read_pipe_pkg::slot_t  job_slot;
read_pipe_pkg::rows_t  job_rows;
read_pipe_pkg::row_t   job_first;
read_pipe_pkg::row_t   job_step;
read_pipe_pkg::rows_t  job_count;

logic                  addr_rdy;
logic                  addr_ack;
read_pipe_pkg::laddr_t addr;
logic                  addr_retire;

logic                  free_dval;
read_pipe_pkg::slot_t  free_slot;

buffer_allocator u_alloc (
	.i_clk            (i_clk),
	.i_reset          (i_reset),
	.i_bofs_rdy       (i_bofs_rdy),
	.o_bofs_ack       (o_bofs_ack),
	.i_bofs           (i_bofs),
	.i_rows           (i_rows),
	.i_first          (i_first),
	.i_step           (i_step),
	.i_count          (i_count),
	.o_rp_en_rdy      (o_rp_en_rdy),
	.i_rp_en_ack      (i_rp_en_ack),
	.o_rp_en_slot     (o_rp_en_slot),
	.o_rp_en_bofs     (o_rp_en_bofs),
	.o_rp_en_rows     (o_rp_en_rows),
	.i_dma_write_dval (i_dma_write_dval),
	.o_job_rdy        (job_rdy),
	.i_job_ack        (job_ack),
	.o_job_slot       (job_slot),
	.o_job_rows       (job_rows),
	.o_job_first      (job_first),
	.o_job_step       (job_step),
	.o_job_count      (job_count),
	.i_free_dval      (free_dval),
	.i_free_slot      (free_slot)
);

warp_address_looper u_awl (
	.i_clk       (i_clk),
	.i_reset     (i_reset),
	.i_job_rdy   (job_rdy),
	.o_job_ack   (job_ack),
	.i_job_slot  (job_slot),
	.i_job_rows  (job_rows),
	.i_job_first (job_first),
	.i_job_step  (job_step),
	.i_job_count (job_count),
	.o_addr_rdy  (addr_rdy),
	.i_addr_ack  (addr_ack),
	.o_addr      (addr),
	.o_retire    (addr_retire)
);

remap_buffer u_rmb (
	.i_clk            (i_clk),
	.i_reset          (i_reset),
	.i_xor_mask       (i_xor_mask),
	.i_dma_write_dval (i_dma_write_dval),
	.i_dma_whiaddr    (i_dma_whiaddr),
	.i_dma_wdata      (i_dma_wdata),
	.i_addr_rdy       (addr_rdy),
	.o_addr_ack       (addr_ack),
	.i_addr           (addr),
	.i_retire         (addr_retire),
	.o_sramrd_rdy     (o_sramrd_rdy),
	.i_sramrd_ack     (i_sramrd_ack),
	.o_sramrd         (o_sramrd),
	.o_free_dval      (free_dval),
	.o_free_slot      (free_slot)
);

endmodule

// File: verif/read_pipeline_tb.sv
//==============================
// Testbench for the read pipeline top. Loads the memory fill key
// and the request list from the test data file, models the DMA,
// drives requests and checks every sramrd vector in order.
//==============================

module read_pipeline_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int VEC_BW      = read_pipe_pkg::VSIZE * read_pipe_pkg::DBW;
localparam int MAX_REQ     = 32;
localparam int MAX_TEST    = 16;
localparam int HOLD_CYCLES = 40;

logic                  i_clk;
logic                  i_reset;
logic                  i_bofs_rdy;
logic                  o_bofs_ack;
read_pipe_pkg::gaddr_t i_bofs;
read_pipe_pkg::rows_t  i_rows;
read_pipe_pkg::row_t   i_first;
read_pipe_pkg::row_t   i_step;
read_pipe_pkg::rows_t  i_count;
logic                  o_rp_en_rdy;
logic                  i_rp_en_ack;
read_pipe_pkg::slot_t  o_rp_en_slot;
read_pipe_pkg::gaddr_t o_rp_en_bofs;
read_pipe_pkg::rows_t  o_rp_en_rows;
logic                  i_dma_write_dval;
read_pipe_pkg::laddr_t i_dma_whiaddr;
read_pipe_pkg::lane_t  i_dma_wdata [read_pipe_pkg::VSIZE];
read_pipe_pkg::xor_t   i_xor_mask;
logic                  o_sramrd_rdy;
logic                  i_sramrd_ack;
read_pipe_pkg::lane_t  o_sramrd [read_pipe_pkg::VSIZE];

// Read ack mode per request is 0 for always, 1 for random and 2 for held
int req_test [MAX_REQ];
int req_bofs [MAX_REQ];
int req_rows [MAX_REQ];
int req_first [MAX_REQ];
int req_step [MAX_REQ];
int req_count [MAX_REQ];
int req_xor [MAX_REQ];
int req_mode [MAX_REQ];
int reads_before [MAX_REQ];
int n_req;

read_pipe_pkg::lane_t    fill_key;
logic [VEC_BW-1:0]       exp_q [$];
int                      exp_req_q [$];
int                      test_reads [MAX_TEST];
int                      test_left [MAX_TEST];
int                      test_err [MAX_TEST];
int                      side_err [MAX_TEST];
int                      total_reads;
int                      reads_done;
int                      extra_err;
int                      tests_passed;
int                      tests_failed;
int                      held_n;
integer                  seed = 25663;
logic                    loaded;
logic                    started;
logic                    hold_reads;

read_pipeline dut (.*);

initial begin
	i_clk = 1'b0;
	forever #50 i_clk = ~i_clk;
end

//==============================
// Helpers
//==============================
function automatic int rand_below(input int n);
	int r;
	r = $random(seed);
	return int'($unsigned(r) % n);
endfunction

// Global memory fill that depends on the full row address and the lane
function automatic read_pipe_pkg::lane_t mem_lane(input int a, input int l);
	logic [7:0] ga;
	logic [3:0] ln;
	ga = a[7:0];
	ln = l[3:0];
	return fill_key ^ {ga, ln, ~ga[3:0]};
endfunction

function automatic logic [VEC_BW-1:0] mem_row(input int a);
	logic [VEC_BW-1:0] v;
	for (int l = 0; l < read_pipe_pkg::VSIZE; l++) begin
		v[l*read_pipe_pkg::DBW +: read_pipe_pkg::DBW] = mem_lane(a, l);
	end
	return v;
endfunction

function automatic logic [VEC_BW-1:0] pack_sramrd();
	logic [VEC_BW-1:0] v;
	for (int l = 0; l < read_pipe_pkg::VSIZE; l++) begin
		v[l*read_pipe_pkg::DBW +: read_pipe_pkg::DBW] = o_sramrd[l];
	end
	return v;
endfunction

// Reads the file and builds the expected vector list
task automatic load_testdata(output logic ok);
	int    fd;
	int    n;
	int    r;
	int    i;
	string text;
	ok = 1'b0;
	n_req = 0;
	total_reads = 0;
	fd = $fopen("verif/read_pipeline_testdata.txt", "r");
	if (fd != 0) begin
		ok = 1'b1;
		while ($fgets(text, fd) != 0) begin
			if (text.len() > 0 && text[0] == "F") begin
				n = $sscanf(text, "F %h", fill_key);
			end else if (text.len() > 0 && text[0] == "R" && n_req < MAX_REQ) begin
				i = n_req;
				n = $sscanf(text, "R %d %h %d %d %d %d %d %d", req_test[i], req_bofs[i],
					req_rows[i], req_first[i], req_step[i], req_count[i], req_xor[i],
					req_mode[i]);
				if (n != 8) begin
					$display("Error: malformed request line in test data file");
					ok = 1'b0;
				end
				reads_before[i] = total_reads;
				// Row walk with wrap by conditional subtraction
				r = req_first[i];
				for (int k = 0; k < req_count[i]; k++) begin
					exp_q.push_back(mem_row(req_bofs[i] + r));
					exp_req_q.push_back(i);
					r = r + req_step[i];
					if (r >= req_rows[i]) begin
						r = r - req_rows[i];
					end
				end
				test_reads[req_test[i]] += req_count[i];
				test_left[req_test[i]] += req_count[i];
				total_reads += req_count[i];
				n_req++;
			end
		end
		$fclose(fd);
	end
endtask

task automatic send_request(input int i);
	int   waited;
	logic acked;
	logic check_hold;
	// Mask only changes once earlier reads and their slot frees are done
	if (int'(i_xor_mask) != req_xor[i]) begin
		wait (reads_done == reads_before[i]);
		repeat (3) @(negedge i_clk);
		i_xor_mask = read_pipe_pkg::xor_t'(req_xor[i]);
	end
	check_hold = 1'b0;
	if (req_mode[i] == 2) begin
		if (held_n == 0) begin
			hold_reads = 1'b1;
		end
		check_hold = (held_n == read_pipe_pkg::N_SLOT);
		held_n++;
	end
	i_bofs     = read_pipe_pkg::gaddr_t'(req_bofs[i]);
	i_rows     = read_pipe_pkg::rows_t'(req_rows[i]);
	i_first    = read_pipe_pkg::row_t'(req_first[i]);
	i_step     = read_pipe_pkg::row_t'(req_step[i]);
	i_count    = read_pipe_pkg::rows_t'(req_count[i]);
	i_bofs_rdy = 1'b1;
	waited = 0;
	acked = 1'b0;
	while (!acked) begin
		@(negedge i_clk);
		if (o_bofs_ack) begin
			acked = 1'b1;
		end else begin
			waited++;
			if (check_hold && waited == HOLD_CYCLES) begin
				hold_reads = 1'b0;
			end
		end
	end
	if (check_hold) begin
		assert (waited >= HOLD_CYCLES) else begin
			$display("Error: request %0d was acked while both slots were busy and unread", i);
			side_err[req_test[i]]++;
		end
	end
	// Transfer happens on the coming rising edge
	@(negedge i_clk);
	i_bofs_rdy = 1'b0;
endtask

//==============================
// DMA model
//==============================
initial begin : dma_model
	read_pipe_pkg::slot_t  slot;
	read_pipe_pkg::gaddr_t want_bofs;
	read_pipe_pkg::rows_t  want_rows;
	int                    base;
	int                    nrows;
	int                    notify_n;
	int                    t;
	i_rp_en_ack = 1'b0;
	i_dma_write_dval = 1'b0;
	i_dma_whiaddr = '0;
	for (int l = 0; l < read_pipe_pkg::VSIZE; l++) begin
		i_dma_wdata[l] = '0;
	end
	notify_n = 0;
	wait (started);
	forever begin
		@(negedge i_clk);
		if (o_rp_en_rdy) begin
			slot = o_rp_en_slot;
			base = int'(o_rp_en_bofs);
			nrows = int'(o_rp_en_rows);
			// Notifies come in request order
			assert (notify_n < n_req) else begin
				$display("Error: DMA notify raised with no request pending");
				extra_err++;
			end
			if (notify_n < n_req) begin
				t = req_test[notify_n];
				want_bofs = read_pipe_pkg::gaddr_t'(req_bofs[notify_n]);
				want_rows = read_pipe_pkg::rows_t'(req_rows[notify_n]);
				assert (o_rp_en_bofs == want_bofs) else begin
					$display("Fail test %0d: o_rp_en_bofs expected %h actual %h",
						t, want_bofs, o_rp_en_bofs);
					side_err[t]++;
				end
				assert (o_rp_en_rows == want_rows) else begin
					$display("Fail test %0d: o_rp_en_rows expected %h actual %h",
						t, want_rows, o_rp_en_rows);
					side_err[t]++;
				end
				notify_n++;
			end
			repeat (rand_below(4)) @(negedge i_clk);
			i_rp_en_ack = 1'b1;
			@(negedge i_clk);
			i_rp_en_ack = 1'b0;
			for (int r = 0; r < nrows; r++) begin
				repeat (rand_below(3)) @(negedge i_clk);
				i_dma_write_dval = 1'b1;
				i_dma_whiaddr = {slot, read_pipe_pkg::row_t'(r)};
				for (int l = 0; l < read_pipe_pkg::VSIZE; l++) begin
					i_dma_wdata[l] = mem_lane(base + r, l);
				end
				@(negedge i_clk);
				i_dma_write_dval = 1'b0;
			end
		end
	end
end

//==============================
// Read checker
//==============================
initial begin : read_checker
	logic              ack;
	logic [VEC_BW-1:0] want;
	logic [VEC_BW-1:0] got;
	int                idx;
	int                t;
	i_sramrd_ack = 1'b0;
	wait (started);
	forever begin
		@(negedge i_clk);
		ack = 1'b1;
		if (exp_q.size() > 0) begin
			if (req_mode[exp_req_q[0]] == 1) begin
				ack = (rand_below(3) != 0);
			end else if (req_mode[exp_req_q[0]] == 2) begin
				ack = ~hold_reads;
			end
		end
		i_sramrd_ack = ack;
		if (o_sramrd_rdy && ack) begin
			got = pack_sramrd();
			assert (exp_q.size() > 0) else begin
				$display("Error: unexpected read vector %h with no read pending", got);
				extra_err++;
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				idx = exp_req_q.pop_front();
				t = req_test[idx];
				assert (got == want) else begin
					$display("Fail test %0d read %0d: o_sramrd expected %h actual %h",
						t, reads_done, want, got);
					test_err[t]++;
				end
				reads_done++;
				test_left[t]--;
				if (test_left[t] == 0) begin
					if (test_err[t] + side_err[t] == 0) begin
						tests_passed++;
						$display("Test %0d passed: %0d reads", t, test_reads[t]);
					end else begin
						tests_failed++;
						$display("Test %0d failed: %0d reads, %0d errors", t, test_reads[t],
							test_err[t] + side_err[t]);
					end
				end
			end
		end
	end
end

initial begin : watchdog
	int limit;
	wait (loaded);
	limit = total_reads * 20 + 1000;
	repeat (limit) @(posedge i_clk);
	$display("Timeout: the run did not finish within %0d cycles", limit);
	$display("=== FAIL ===");
	$finish;
end

//==============================
// Main sequence
//==============================
initial begin : main_seq
	logic ok;
	int   idle_err;
	int   total_err;
	i_reset = 1'b1;
	i_bofs_rdy = 1'b0;
	i_bofs = '0;
	i_rows = '0;
	i_first = '0;
	i_step = '0;
	i_count = '0;
	i_xor_mask = '0;
	loaded = 1'b0;
	started = 1'b0;
	hold_reads = 1'b0;
	held_n = 0;
	idle_err = 0;
	load_testdata(ok);
	if (!ok) begin
		$display("Error: test data file missing or unreadable");
		$display("=== FAIL ===");
		$finish;
	end else begin
		loaded = 1'b1;
		repeat (4) @(negedge i_clk);
		i_reset = 1'b0;
		started = 1'b1;
		// Nothing may be offered before the first request
		repeat (5) begin
			@(negedge i_clk);
			assert (!o_rp_en_rdy && !o_sramrd_rdy) else begin
				$display("Error: rp_en or sramrd rdy raised with no request pending");
				idle_err++;
			end
		end
		$display("Test 0 %s: idle outputs after reset", (idle_err == 0) ? "passed" : "failed");
		for (int i = 0; i < n_req; i++) begin
			send_request(i);
		end
		wait (reads_done == total_reads);
		repeat (5) @(negedge i_clk);
		total_err = idle_err + extra_err;
		for (int t = 0; t < MAX_TEST; t++) begin
			total_err += test_err[t] + side_err[t];
		end
		$display("Summary: %0d tests passed, %0d failed, %0d of %0d reads, %0d errors",
			tests_passed + ((idle_err == 0) ? 1 : 0),
			tests_failed + ((idle_err == 0) ? 0 : 1), reads_done, total_reads, total_err);
		if (total_err == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end
end

endmodule

// File: verif/read_pipeline_testdata.txt
# F key: global memory fill, lane l of row a = key ^ {a[7:0], l[3:0], ~a[3:0]}
# R test bofs(hex) rows first step count xor_mask mode (0 ack high, 1 random ack, 2 held)
F 5a3c
R 1 10 8 0 1 8 0 0
R 1 40 5 0 1 5 0 0
R 2 23 5 3 2 7 0 0
R 2 80 7 6 3 8 0 0
R 3 31 8 2 5 8 0 1
R 3 fe 6 1 1 6 0 1
R 4 50 8 0 1 8 1 0
R 4 58 8 7 3 8 2 0
R 4 60 8 0 1 8 3 1
R 4 68 6 0 1 6 0 0
R 5 00 8 0 1 8 0 1
R 5 08 3 1 2 5 0 1
R 5 c0 8 4 7 8 0 1
R 5 12 1 0 0 3 0 1
R 5 e0 6 5 4 6 0 1
R 5 77 8 3 3 8 0 1
R 6 a0 8 0 1 8 2 2
R 6 b0 4 2 1 4 2 2
R 6 c8 8 1 3 8 2 2

// File: sim.f
rtl/read_pipe_pkg.sv
rtl/buffer_allocator.sv
rtl/warp_address_looper.sv
rtl/remap_buffer.sv
rtl/read_pipeline.sv
verif/read_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module read_pipeline_tb -o sim_read_pipeline
./obj_dir/sim_read_pipeline > sim.log 2>&1
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
